/* src/riscv_pkg.sv */
// --------------------
// architectural constants of the RISC-V ISA used by the load/store front end
// register width, Sv39 virtual address width and the exception causes that
// the front end can raise
// import where ISA-level widths or cause codes are needed
// --------------------

`default_nettype none

package riscv_pkg;

    // --------------------
    // widths
    // --------------------
    // 64-bit core
    localparam int unsigned xlen = 64;
    // Sv39 virtual addresses
    localparam int unsigned vlen = 39;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [vlen-1:0] vaddr_t;

    // --------------------
    // exception causes
    // --------------------
    // mcause encoding, one full register word
    typedef logic [xlen-1:0] exc_cause_t;

    localparam exc_cause_t LD_ADDR_MISALIGNED = 64'd4;
    localparam exc_cause_t LD_ACCESS_FAULT    = 64'd5;
    localparam exc_cause_t ST_ADDR_MISALIGNED = 64'd6;
    localparam exc_cause_t ST_ACCESS_FAULT    = 64'd7;

endpackage

`default_nettype wire

/* src/lsu_pkg.sv */
// --------------------
// micro-architectural types of the load/store front end
// operation codes, the incoming request from issue, the buffered control
// word and the request handed to the load and store issue ports
// --------------------

`default_nettype none

package lsu_pkg;

    // scoreboard tag
    localparam int unsigned trans_id_bits = 3;
    typedef logic [trans_id_bits-1:0] trans_id_t;

    // target functional unit
    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE
    } fu_t;

    // integer loads and stores only
    typedef enum logic [3:0] {
        LD, SD,
        LW, LWU, SW,
        LH, LHU, SH,
        LB, LBU, SB
    } lsu_op_t;

    typedef logic [7:0] be_t;

    typedef struct packed {
        riscv_pkg::exc_cause_t cause;
        riscv_pkg::xlen_t      tval;
        logic                  valid;
    } exception_t;

    // request as it leaves issue
    typedef struct packed {
        fu_t              fu;
        lsu_op_t          op;
        riscv_pkg::xlen_t operand_a;
        riscv_pkg::xlen_t operand_b;
        riscv_pkg::xlen_t imm;
        trans_id_t        trans_id;
    } fu_data_t;

    // request after address generation, as held in the bypass buffer
    typedef struct packed {
        logic              valid;
        riscv_pkg::vaddr_t vaddr;
        logic              overflow;
        riscv_pkg::xlen_t  data;
        be_t               be;
        fu_t               fu;
        lsu_op_t           op;
        trans_id_t         trans_id;
    } lsu_ctrl_t;

    // request towards the load or store unit
    typedef struct packed {
        logic              valid;
        riscv_pkg::vaddr_t vaddr;
        riscv_pkg::xlen_t  data;
        be_t               be;
        lsu_op_t           op;
        trans_id_t         trans_id;
        exception_t        ex;
    } lsu_issue_t;

    // log2 of the access size in bytes
    function automatic logic [1:0] op_size(lsu_op_t op);
        unique case (op)
            LD, SD:          return 2'd3;
            LW, LWU, SW:     return 2'd2;
            LH, LHU, SH:     return 2'd1;
            default:         return 2'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/lsu_agu.sv */
// --------------------
// address generation for loads and stores
// adds the immediate to the base, flags addresses outside the Sv39 range
// and builds the byte enables from the size and the low address bits
// purely combinational, feeds the bypass buffer
// --------------------

`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
    input  logic               lsu_valid_i,
    input  lsu_pkg::fu_data_t  fu_data_i,
    output lsu_pkg::lsu_ctrl_t lsu_req_o
);
    import riscv_pkg::*;
    import lsu_pkg::*;

    xlen_t    vaddr_xlen;
    vaddr_t   vaddr;
    logic     overflow;
    logic [1:0] size;
    be_t      be_mask;
    logic [15:0] be_wide;
    be_t      be;

    // --------------------
    // address
    // --------------------
    assign vaddr_xlen = $unsigned($signed(fu_data_i.imm) + $signed(fu_data_i.operand_a));
    assign vaddr      = vaddr_xlen[vlen-1:0];

    // upper bits must all copy bit 38
    assign overflow = !((&vaddr_xlen[xlen-1:vlen-1]) || !(|vaddr_xlen[xlen-1:vlen-1]));

    // --------------------
    // byte enable
    // --------------------
    assign size = op_size(fu_data_i.op);

    always_comb begin
        unique case (size)
            2'd0:    be_mask = 8'h01;
            2'd1:    be_mask = 8'h03;
            2'd2:    be_mask = 8'h0f;
            default: be_mask = 8'hff;
        endcase
    end

    // shift into place, lanes past byte 7 fall off the top half
    assign be_wide = {8'h00, be_mask} << vaddr[2:0];
    assign be      = be_wide[7:0];

    // --------------------
    // request to the buffer
    // --------------------
    always_comb begin
        lsu_req_o.valid    = lsu_valid_i;
        lsu_req_o.vaddr    = vaddr;
        lsu_req_o.overflow = overflow;
        // store data travels with the request
        lsu_req_o.data     = fu_data_i.operand_b;
        lsu_req_o.be       = be;
        lsu_req_o.fu       = fu_data_i.fu;
        lsu_req_o.op       = fu_data_i.op;
        lsu_req_o.trans_id = fu_data_i.trans_id;
    end

endmodule

`default_nettype wire

/* src/lsu_bypass.sv */
// --------------------
// bypass buffer between address generation and dispatch
// holds requests the load or store unit has not taken yet
// an incoming request passes straight through while the buffer is empty,
// otherwise the oldest stored entry is presented until popped
// --------------------

`timescale 1ns/1ps
`default_nettype none

module lsu_bypass #(
    parameter int unsigned depth = 2
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  lsu_pkg::lsu_ctrl_t lsu_req_i,
    input  logic               pop_ld_i,
    input  logic               pop_st_i,
    output lsu_pkg::lsu_ctrl_t lsu_ctrl_o,
    output logic               ready_o
);
    import lsu_pkg::*;

    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned cnt_w = $clog2(depth + 1);

    lsu_ctrl_t              mem_q [depth];
    logic [depth-1:0]       valid_q;
    logic [depth-1:0]       valid_n;
    logic [ptr_w-1:0]       rd_ptr_q;
    logic [ptr_w-1:0]       rd_ptr_n;
    logic [ptr_w-1:0]       wr_ptr_q;
    logic [ptr_w-1:0]       wr_ptr_n;
    logic [cnt_w-1:0]       cnt_q;
    logic [cnt_w-1:0]       cnt_n;
    logic                   push;
    logic                   pop;
    logic                   empty;
    logic                   full;

    assign push  = lsu_req_i.valid;
    assign pop   = pop_ld_i | pop_st_i;
    assign empty = (cnt_q == '0);
    assign full  = (cnt_q == cnt_w'(depth));

    assign ready_o = empty;

    // --------------------
    // next state
    // --------------------
    always_comb begin
        valid_n  = valid_q;
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;

        if (push) begin
            valid_n[wr_ptr_q] = 1'b1;
            wr_ptr_n = (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        // a pop of the bypassed request clears the slot it was written to
        if (pop) begin
            valid_n[rd_ptr_q] = 1'b0;
            rd_ptr_n = (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
        end

        unique case ({push, pop})
            2'b10:   cnt_n = cnt_q + 1'b1;
            2'b01:   cnt_n = cnt_q - 1'b1;
            default: cnt_n = cnt_q;
        endcase

        if (flush_i) begin
            valid_n  = '0;
            rd_ptr_n = '0;
            wr_ptr_n = '0;
            cnt_n    = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            valid_q  <= valid_n;
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    // payload storage
    always_ff @(posedge clk_i) begin
        if (push && !flush_i) begin
            mem_q[wr_ptr_q] <= lsu_req_i;
        end
    end

    // --------------------
    // head output
    // --------------------
    always_comb begin
        if (empty) begin
            lsu_ctrl_o = lsu_req_i;
        end else begin
            lsu_ctrl_o       = mem_q[rd_ptr_q];
            lsu_ctrl_o.valid = valid_q[rd_ptr_q];
        end
    end

    // source must hold off once the buffer is full
    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(push && full && !flush_i));

    // load and store unit never consume the same head
    a_one_pop : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pop_ld_i && pop_st_i));

endmodule

`default_nettype wire

/* src/lsu_dispatch.sv */
// --------------------
// dispatch of the buffer head to the load or store issue port
// detects misaligned addresses and, with translation on, addresses outside
// the Sv39 range, and attaches the exception to the outgoing request
// purely combinational
// --------------------

`timescale 1ns/1ps
`default_nettype none

module lsu_dispatch (
    input  lsu_pkg::lsu_ctrl_t  lsu_ctrl_i,
    input  logic                en_translation_i,
    output lsu_pkg::lsu_issue_t ld_issue_o,
    output lsu_pkg::lsu_issue_t st_issue_o
);
    import riscv_pkg::*;
    import lsu_pkg::*;

    logic       is_load;
    logic       is_store;
    logic       misaligned;
    xlen_t      tval;
    exception_t ex;
    lsu_issue_t issue;

    assign is_load  = (lsu_ctrl_i.fu == LOAD);
    assign is_store = (lsu_ctrl_i.fu == STORE);

    // faulting address zero-extended to a full word
    assign tval = {{(xlen - vlen){1'b0}}, lsu_ctrl_i.vaddr};

    // --------------------
    // misalignment
    // --------------------
    always_comb begin
        unique case (op_size(lsu_ctrl_i.op))
            2'd3:    misaligned = |lsu_ctrl_i.vaddr[2:0];
            2'd2:    misaligned = |lsu_ctrl_i.vaddr[1:0];
            2'd1:    misaligned = lsu_ctrl_i.vaddr[0];
            // bytes are always aligned
            default: misaligned = 1'b0;
        endcase
    end

    // --------------------
    // exception select
    // --------------------
    always_comb begin
        ex = '0;
        if (lsu_ctrl_i.valid && (is_load || is_store)) begin
            if (misaligned) begin
                ex.valid = 1'b1;
                ex.cause = is_load ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
                ex.tval  = tval;
            end
            // access fault wins over misalignment
            if (en_translation_i && lsu_ctrl_i.overflow) begin
                ex.valid = 1'b1;
                ex.cause = is_load ? LD_ACCESS_FAULT : ST_ACCESS_FAULT;
                ex.tval  = tval;
            end
        end
    end

    // --------------------
    // routing
    // --------------------
    always_comb begin
        issue.valid    = lsu_ctrl_i.valid;
        issue.vaddr    = lsu_ctrl_i.vaddr;
        issue.data     = lsu_ctrl_i.data;
        issue.be       = lsu_ctrl_i.be;
        issue.op       = lsu_ctrl_i.op;
        issue.trans_id = lsu_ctrl_i.trans_id;
        issue.ex       = ex;
    end

    always_comb begin
        ld_issue_o       = issue;
        ld_issue_o.valid = issue.valid && is_load;
        st_issue_o       = issue;
        st_issue_o.valid = issue.valid && is_store;
    end

endmodule

`default_nettype wire

/* src/lsu_frontend.sv */
// --------------------
// load/store unit front end, top level
// address generation, two-entry bypass buffer and load/store dispatch
// lsu_ready_o is high while the buffer is empty, pops come from the
// downstream load and store units
// --------------------

`timescale 1ns/1ps
`default_nettype none

module lsu_frontend #(
    parameter int unsigned buffer_depth = 2
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                lsu_valid_i,
    input  lsu_pkg::fu_data_t   fu_data_i,
    input  logic                en_translation_i,
    input  logic                pop_ld_i,
    input  logic                pop_st_i,
    output logic                lsu_ready_o,
    output lsu_pkg::lsu_issue_t ld_issue_o,
    output lsu_pkg::lsu_issue_t st_issue_o
);
    import lsu_pkg::*;

    // request after address generation
    lsu_ctrl_t lsu_req;
    // oldest pending request
    lsu_ctrl_t lsu_ctrl;

    lsu_agu i_agu (
        .lsu_valid_i ( lsu_valid_i ),
        .fu_data_i   ( fu_data_i   ),
        .lsu_req_o   ( lsu_req     )
    );

    lsu_bypass #(
        .depth ( buffer_depth )
    ) i_bypass (
        .clk_i      ( clk_i       ),
        .rst_ni     ( rst_ni      ),
        .flush_i    ( flush_i     ),
        .lsu_req_i  ( lsu_req     ),
        .pop_ld_i   ( pop_ld_i    ),
        .pop_st_i   ( pop_st_i    ),
        .lsu_ctrl_o ( lsu_ctrl    ),
        .ready_o    ( lsu_ready_o )
    );

    lsu_dispatch i_dispatch (
        .lsu_ctrl_i       ( lsu_ctrl         ),
        .en_translation_i ( en_translation_i ),
        .ld_issue_o       ( ld_issue_o       ),
        .st_issue_o       ( st_issue_o       )
    );

endmodule

`default_nettype wire

/* sim/tb_lsu_frontend.sv */
// --------------------
// self-checking testbench for the load/store front end
// drives aligned, misaligned and out-of-range requests, back-pressure with
// two requests in flight and flushes, and checks both issue ports and
// lsu_ready_o every cycle against a reference model
// --------------------

`timescale 1ns/1ps
`default_nettype none

module tb_lsu_frontend;
    import riscv_pkg::*;
    import lsu_pkg::*;

    localparam int unsigned rounds      = 4;
    localparam int unsigned n_ops       = 11;
    localparam int unsigned n_pairs     = 12;
    localparam int unsigned n_flush     = 3;
    localparam int unsigned n_requests  = 2 * rounds * n_ops + 2 * n_ops + 2 * n_pairs
                                          + 2 * n_flush;
    localparam int unsigned cycle_limit = n_requests * 10 + 20;

    logic        clk_i;
    logic        rst_ni;
    logic        flush_i;
    logic        lsu_valid_i;
    fu_data_t    fu_data_i;
    logic        en_translation_i;
    logic        pop_ld_i;
    logic        pop_st_i;
    logic        lsu_ready_o;
    lsu_issue_t  ld_issue_o;
    lsu_issue_t  st_issue_o;

    // requests accepted by the DUT and not yet popped in arrival order
    fu_data_t    exp_q [$];
    logic [31:0] lfsr_q;
    int unsigned err_count;
    int unsigned check_count;
    int unsigned cycle_count = 0;

    lsu_op_t all_ops [n_ops] = '{LD, SD, LW, LWU, SW, LH, LHU, SH, LB, LBU, SB};

    lsu_frontend #(
        .buffer_depth ( 2 )
    ) DUT (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .flush_i          ( flush_i          ),
        .lsu_valid_i      ( lsu_valid_i      ),
        .fu_data_i        ( fu_data_i        ),
        .en_translation_i ( en_translation_i ),
        .pop_ld_i         ( pop_ld_i         ),
        .pop_st_i         ( pop_st_i         ),
        .lsu_ready_o      ( lsu_ready_o      ),
        .ld_issue_o       ( ld_issue_o       ),
        .st_issue_o       ( st_issue_o       )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // --------------------
    // random numbers
    // --------------------
    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(int unsigned n);
        logic [63:0] r;
        r = '0;
        for (int unsigned i = 0; i < n; i++) begin
            r      = {r[62:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    // --------------------
    // reference model
    // --------------------
    function automatic int unsigned size_bytes(lsu_op_t op);
        case (op)
            LD, SD:      return 8;
            LW, LWU, SW: return 4;
            LH, LHU, SH: return 2;
            default:     return 1;
        endcase
    endfunction

    function automatic lsu_issue_t ref_issue(fu_data_t req, logic en);
        lsu_issue_t  res;
        xlen_t       sum;
        int unsigned bytes;
        int unsigned off;
        logic        is_load;
        res          = '0;
        sum          = req.operand_a + req.imm;
        bytes        = size_bytes(req.op);
        off          = 32'(sum[2:0]);
        is_load      = (req.fu == LOAD);
        res.valid    = 1'b1;
        res.vaddr    = sum[vlen-1:0];
        res.data     = req.operand_b;
        res.op       = req.op;
        res.trans_id = req.trans_id;
        // lanes past byte 7 stay off
        for (int unsigned i = 0; i < bytes; i++) begin
            if (off + i < 8) begin
                res.be[off + i] = 1'b1;
            end
        end
        if (off % bytes != 0) begin
            res.ex.valid = 1'b1;
            res.ex.cause = is_load ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
            res.ex.tval  = xlen_t'(res.vaddr);
        end
        // top bits must be a sign extension of bit 38
        if (en && (sum[63:38] != {26{sum[38]}})) begin
            res.ex.valid = 1'b1;
            res.ex.cause = is_load ? LD_ACCESS_FAULT : ST_ACCESS_FAULT;
            res.ex.tval  = xlen_t'(res.vaddr);
        end
        return res;
    endfunction

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_issue(lsu_issue_t act, lsu_issue_t exp_v, string what);
        check_count++;
        if (act.valid !== exp_v.valid) begin
            err_count++;
            $display("Fail %0t: %s valid %b, expected %b", $time, what, act.valid,
                     exp_v.valid);
        end else if (exp_v.valid && (act !== exp_v)) begin
            err_count++;
            $display("Fail %0t: %s got %h, expected %h", $time, what, act, exp_v);
        end
    endtask

    task automatic check_ready(logic act, logic exp_v, string what);
        check_count++;
        if (act !== exp_v) begin
            err_count++;
            $display("Fail %0t: %s is %b, expected %b", $time, what, act, exp_v);
        end
    endtask

    // model update and comparison once per cycle after inputs settle
    initial begin : compare_proc
        lsu_issue_t exp_ld;
        lsu_issue_t exp_st;
        lsu_issue_t head;
        wait (rst_ni === 1'b1);
        forever begin
            @(negedge clk_i);
            #2;
            check_ready(lsu_ready_o, exp_q.size() == 0, "lsu_ready_o");
            if (lsu_valid_i) begin
                exp_q.push_back(fu_data_i);
            end
            exp_ld = '0;
            exp_st = '0;
            if (exp_q.size() > 0) begin
                head = ref_issue(exp_q[0], en_translation_i);
                if (exp_q[0].fu == LOAD) begin
                    exp_ld = head;
                end else begin
                    exp_st = head;
                end
            end
            check_issue(ld_issue_o, exp_ld, "load port");
            check_issue(st_issue_o, exp_st, "store port");
            if ((pop_ld_i || pop_st_i) && (exp_q.size() > 0)) begin
                void'(exp_q.pop_front());
            end
            if (flush_i) begin
                exp_q.delete();
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    task automatic drive(logic valid, fu_data_t req, logic en, logic pop_ld, logic pop_st,
                         logic flush);
        @(negedge clk_i);
        lsu_valid_i      = valid;
        fu_data_i        = req;
        en_translation_i = en;
        pop_ld_i         = pop_ld;
        pop_st_i         = pop_st;
        flush_i          = flush;
    endtask

    task automatic wait_ready();
        while (lsu_ready_o !== 1'b1) begin
            drive(1'b0, '0, en_translation_i, 1'b0, 1'b0, 1'b0);
        end
    endtask

    // ovf puts the address outside the Sv39 range
    function automatic fu_data_t make_req(lsu_op_t op, logic [2:0] low, logic ovf);
        fu_data_t    req;
        logic [63:0] r;
        req.op = op;
        req.fu = (op inside {SD, SW, SH, SB}) ? STORE : LOAD;
        r      = rand_bits(38);
        if (!ovf) begin
            req.operand_a = {32'd0, r[31:3], low};
        end else if (r[37]) begin
            req.operand_a = {25'd0, 1'b1, r[34:0], low};
        end else begin
            req.operand_a = {25'h1ff_ffff, 1'b0, r[34:0], low};
        end
        r             = rand_bits(12);
        req.imm       = {{52{r[11]}}, r[11:3], 3'b000};
        req.operand_b = rand_bits(64);
        req.trans_id  = trans_id_t'(rand_bits(trans_id_bits));
        return req;
    endfunction

    // accepted and popped in the same cycle
    task automatic send_pop(fu_data_t req, logic en);
        wait_ready();
        drive(1'b1, req, en, req.fu == LOAD, req.fu == STORE, 1'b0);
    endtask

    task automatic run_aligned();
        logic [2:0] low;
        for (int unsigned r = 0; r < rounds; r++) begin
            for (int unsigned i = 0; i < n_ops; i++) begin
                low = 3'(rand_bits(3));
                low = low - 3'(low % size_bytes(all_ops[i]));
                send_pop(make_req(all_ops[i], low, 1'b0), 1'b1);
            end
        end
    endtask

    task automatic run_misaligned();
        logic [2:0] low;
        for (int unsigned r = 0; r < rounds; r++) begin
            for (int unsigned i = 0; i < n_ops; i++) begin
                // odd offset is wrong for every size above a byte
                low = {2'(rand_bits(2)), 1'b1};
                send_pop(make_req(all_ops[i], low, 1'b0), 1'b0);
            end
        end
    endtask

    // random offsets let misalignment meet the access fault
    task automatic run_overflow();
        for (int unsigned i = 0; i < n_ops; i++) begin
            send_pop(make_req(all_ops[i], 3'(rand_bits(3)), 1'b1), 1'b1);
            send_pop(make_req(all_ops[i], 3'(rand_bits(3)), 1'b1), 1'b0);
        end
    endtask

    // two in flight and each held on its port for a random number of cycles
    task automatic pair_with_delays();
        fu_data_t    a;
        fu_data_t    b;
        logic        en;
        int unsigned d1;
        int unsigned d2;
        a  = make_req(all_ops[int'(rand_bits(4) % 11)], 3'(rand_bits(3)), 1'b0);
        b  = make_req(all_ops[int'(rand_bits(4) % 11)], 3'(rand_bits(3)), 1'b0);
        en = 1'(rand_bits(1));
        d1 = 32'(rand_bits(2));
        d2 = 32'(rand_bits(2));
        wait_ready();
        drive(1'b1, a, en, 1'b0, 1'b0, 1'b0);
        drive(1'b1, b, en, 1'b0, 1'b0, 1'b0);
        repeat (d1) drive(1'b0, '0, en, 1'b0, 1'b0, 1'b0);
        drive(1'b0, '0, en, a.fu == LOAD, a.fu == STORE, 1'b0);
        repeat (d2) drive(1'b0, '0, en, 1'b0, 1'b0, 1'b0);
        drive(1'b0, '0, en, b.fu == LOAD, b.fu == STORE, 1'b0);
    endtask

    task automatic flush_pending();
        wait_ready();
        drive(1'b1, make_req(all_ops[int'(rand_bits(4) % 11)], 3'd0, 1'b0), 1'b0,
              1'b0, 1'b0, 1'b0);
        drive(1'b1, make_req(all_ops[int'(rand_bits(4) % 11)], 3'd0, 1'b0), 1'b0,
              1'b0, 1'b0, 1'b0);
        drive(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b1);
        drive(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        lsu_valid_i      = 1'b0;
        fu_data_i        = '0;
        en_translation_i = 1'b0;
        pop_ld_i         = 1'b0;
        pop_st_i         = 1'b0;
        lfsr_q           = 32'hc3da4745;
        err_count        = 0;
        check_count      = 0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        run_aligned();
        run_misaligned();
        run_overflow();
        repeat (n_pairs) pair_with_delays();
        repeat (n_flush) flush_pending();
        wait_ready();
        drive(1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        @(posedge clk_i);

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_frontend.f */
src/riscv_pkg.sv
src/lsu_pkg.sv
src/lsu_agu.sv
src/lsu_bypass.sv
src/lsu_dispatch.sv
src/lsu_frontend.sv
sim/tb_lsu_frontend.sv

/* Makefile */
# Verilator build and run of the LSU front-end testbench

TOP             ?= tb_lsu_frontend
FILELIST        ?= lsu_frontend.f
LOG             ?= sim.log
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation reported failures, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
